//--- include/exec_defs.svh
//////////////////////////////////////////////////////////////////////
// Widths and fixed constants of the execute stage
// Included by the package and by units that size their own logic
//////////////////////////////////////////////////////////////////////

`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Data path width
`define EXEC_XLEN        32

// Flow tag width
`define EXEC_TAG_BITS    3

// Shift amount taken from the second operand
`define EXEC_SHAMT_BITS  5

// Byte lanes in one data word
`define EXEC_BYTES       4

// Link increment for JAL and JALR
`define EXEC_LINK_OFFSET 4

`endif

//--- logic/exec_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the execute stage, imported by every unit
//////////////////////////////////////////////////////////////////////

`include "exec_defs.svh"

package exec_pkg;

    // Plain vector types
    typedef logic [`EXEC_XLEN-1:0]     word_t;
    typedef logic [`EXEC_TAG_BITS-1:0] tag_t;
    typedef logic [`EXEC_BYTES-1:0]    byte_en_t;

    // Decoded operation from the decode stage
    typedef enum logic [5:0] {
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA, SLT, SLTU, LUI,
        JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        ECALL, EBREAK, MRET,
        NOP
    } op_e;

    // Machine cause codes, NE means no exception
    typedef enum logic [3:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 4'd0,
        ILLEGAL_INSTRUCTION            = 4'd2,
        BREAKPOINT                     = 4'd3,
        ECALL_FROM_MMODE               = 4'd11,
        NE                             = 4'd15
    } exc_code_e;

    typedef struct packed {
        word_t first;
        word_t second;
        word_t third;
    } operands_t;

    typedef struct packed {
        word_t    address;
        logic     read_enable;
        byte_en_t write_enable;
        word_t    write_data;
    } mem_req_t;

    typedef struct packed {
        logic      raise_exception;
        logic      machine_return;
        logic      interrupt_ack;
        exc_code_e exception_code;
    } trap_t;

endpackage

//--- logic/alu_branch.sv
//////////////////////////////////////////////////////////////////////
// Integer ALU with branch compare and jump target, purely combinational
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_defs.svh"

module alu_branch (
    input  exec_pkg::op_e       op_i,
    input  exec_pkg::word_t     pc_i,
    input  exec_pkg::operands_t operands_i,
    output exec_pkg::word_t     result_o,
    output logic                branch_taken_o,
    output exec_pkg::word_t     jump_target_o
);

    import exec_pkg::*;

    word_t                        sum;
    word_t                        sum2_a;
    word_t                        sum2_b;
    word_t                        sum2;
    logic [`EXEC_SHAMT_BITS-1:0]  shamt;
    logic signed [`EXEC_XLEN-1:0] first_signed;
    logic signed [`EXEC_XLEN-1:0] second_signed;
    logic                         equal;
    logic                         less_than;
    logic                         less_than_u;

    assign first_signed  = operands_i.first;
    assign second_signed = operands_i.second;
    assign shamt         = operands_i.second[`EXEC_SHAMT_BITS-1:0];

    //////////////////////////////////////////////////////////////////////
    // Adders
    //////////////////////////////////////////////////////////////////////

    assign sum = operands_i.first + operands_i.second;

    // Second adder serves SUB, the link value and branch targets
    always_comb begin
        case (op_i)
            SUB:     sum2_a = operands_i.first;
            default: sum2_a = pc_i;
        endcase
    end

    always_comb begin
        case (op_i)
            JAL, JALR: sum2_b = word_t'(`EXEC_LINK_OFFSET);
            SUB:       sum2_b = -operands_i.second;
            default:   sum2_b = operands_i.third;
        endcase
    end

    assign sum2 = sum2_a + sum2_b;

    //////////////////////////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            SUB, JAL, JALR: result_o = sum2;
            AND:            result_o = operands_i.first & operands_i.second;
            OR:             result_o = operands_i.first | operands_i.second;
            XOR:            result_o = operands_i.first ^ operands_i.second;
            SLL:            result_o = operands_i.first << shamt;
            SRL:            result_o = operands_i.first >> shamt;
            SRA:            result_o = word_t'(first_signed >>> shamt);
            SLT:            result_o = word_t'(less_than);
            SLTU:           result_o = word_t'(less_than_u);
            LUI:            result_o = operands_i.second;
            default:        result_o = sum;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Branch decision and target
    //////////////////////////////////////////////////////////////////////

    assign equal       = operands_i.first == operands_i.second;
    assign less_than   = first_signed < second_signed;
    assign less_than_u = operands_i.first < operands_i.second;

    always_comb begin
        case (op_i)
            BEQ:       branch_taken_o = equal;
            BNE:       branch_taken_o = !equal;
            BLT:       branch_taken_o = less_than;
            BLTU:      branch_taken_o = less_than_u;
            BGE:       branch_taken_o = !less_than;
            BGEU:      branch_taken_o = !less_than_u;
            JAL, JALR: branch_taken_o = 1'b1;
            default:   branch_taken_o = 1'b0;
        endcase
    end

    // JALR target drops bit 0 of the sum
    always_comb begin
        case (op_i)
            JAL:     jump_target_o = sum;
            JALR:    jump_target_o = {sum[`EXEC_XLEN-1:1], 1'b0};
            default: jump_target_o = sum2;
        endcase
    end

endmodule

//--- logic/load_store_unit.sv
//////////////////////////////////////////////////////////////////////
// Load and store request generation, combinational from the operands
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_defs.svh"

module load_store_unit (
    input  exec_pkg::op_e       op_i,
    input  exec_pkg::operands_t operands_i,
    output exec_pkg::mem_req_t  mem_req_o
);

    import exec_pkg::*;

    word_t addr_sum;

    assign addr_sum = operands_i.first + operands_i.second;

    // Word aligned address
    assign mem_req_o.address     = {addr_sum[`EXEC_XLEN-1:2], 2'b00};
    assign mem_req_o.read_enable = op_i inside {LB, LBU, LH, LHU, LW};

    // Lane select from the low address bits
    always_comb begin
        case (op_i)
            SB:      mem_req_o.write_enable = byte_en_t'(1) << addr_sum[1:0];
            SH:      mem_req_o.write_enable = addr_sum[1] ? 4'b1100 : 4'b0011;
            SW:      mem_req_o.write_enable = 4'b1111;
            default: mem_req_o.write_enable = 4'b0000;
        endcase
    end

    // Narrow stores are copied to every lane
    always_comb begin
        case (op_i)
            SB:      mem_req_o.write_data = {`EXEC_BYTES{operands_i.third[7:0]}};
            SH:      mem_req_o.write_data = {(`EXEC_BYTES/2){operands_i.third[15:0]}};
            default: mem_req_o.write_data = operands_i.third;
        endcase
    end

endmodule

//--- logic/flow_control.sv
//////////////////////////////////////////////////////////////////////
// Flow tag, kill decision, jump gating and trap priority
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module flow_control (
    input  logic              clk,
    input  logic              reset,
    input  exec_pkg::op_e     op_i,
    input  exec_pkg::tag_t    tag_i,
    input  logic              branch_taken_i,
    input  logic              illegal_inst_i,
    input  logic              misaligned_fetch_i,
    input  logic              interrupt_pending_i,
    output logic              killed_o,
    output logic              jump_o,
    output exec_pkg::trap_t   trap_o
);

    import exec_pkg::*;

    tag_t curr_tag;
    logic active;

    // Instructions from an older flow carry a stale tag
    assign killed_o = curr_tag != tag_i;
    assign active   = !killed_o && !reset;
    assign jump_o   = branch_taken_i && active;

    //////////////////////////////////////////////////////////////////////
    // Trap priority
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        trap_o.raise_exception = 1'b0;
        trap_o.machine_return  = 1'b0;
        trap_o.interrupt_ack   = 1'b0;
        trap_o.exception_code  = NE;
        if (active) begin
            if (illegal_inst_i) begin
                trap_o.raise_exception = 1'b1;
                trap_o.exception_code  = ILLEGAL_INSTRUCTION;
            end else if (misaligned_fetch_i) begin
                trap_o.raise_exception = 1'b1;
                trap_o.exception_code  = INSTRUCTION_ADDRESS_MISALIGNED;
            end else if (op_i == ECALL) begin
                trap_o.raise_exception = 1'b1;
                trap_o.exception_code  = ECALL_FROM_MMODE;
            end else if (op_i == EBREAK) begin
                trap_o.raise_exception = 1'b1;
                trap_o.exception_code  = BREAKPOINT;
            end else if (op_i == MRET) begin
                trap_o.machine_return = 1'b1;
            end else if (interrupt_pending_i) begin
                // interrupts only taken when nothing else fires
                trap_o.interrupt_ack = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tag register
    //////////////////////////////////////////////////////////////////////

    // Any change of flow opens a new tag
    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (jump_o || trap_o.raise_exception || trap_o.machine_return
                     || trap_o.interrupt_ack) begin
            curr_tag <= tag_t'(curr_tag + 1'b1);
        end
    end

endmodule

//--- logic/execute_stage.sv
//////////////////////////////////////////////////////////////////////
// Execute stage top, joins the units and holds the output register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall_i,
    input  exec_pkg::op_e       op_i,
    input  exec_pkg::word_t     pc_i,
    input  exec_pkg::operands_t operands_i,
    input  exec_pkg::tag_t      tag_i,
    input  logic                illegal_inst_i,
    input  logic                misaligned_fetch_i,
    input  logic                interrupt_pending_i,
    output logic                killed_o,
    output logic                write_enable_o,
    output exec_pkg::op_e       op_o,
    output exec_pkg::word_t     result_o,
    output exec_pkg::mem_req_t  mem_req_o,
    output logic                jump_o,
    output exec_pkg::word_t     jump_target_o,
    output exec_pkg::trap_t     trap_o
);

    import exec_pkg::*;

    word_t alu_result;
    logic  branch_taken;
    logic  write_enable;

    alu_branch i_alu_branch (
        .op_i           (op_i),
        .pc_i           (pc_i),
        .operands_i     (operands_i),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken),
        .jump_target_o  (jump_target_o)
    );

    load_store_unit i_load_store_unit (
        .op_i       (op_i),
        .operands_i (operands_i),
        .mem_req_o  (mem_req_o)
    );

    flow_control i_flow_control (
        .clk                 (clk),
        .reset               (reset),
        .op_i                (op_i),
        .tag_i               (tag_i),
        .branch_taken_i      (branch_taken),
        .illegal_inst_i      (illegal_inst_i),
        .misaligned_fetch_i  (misaligned_fetch_i),
        .interrupt_pending_i (interrupt_pending_i),
        .killed_o            (killed_o),
        .jump_o              (jump_o),
        .trap_o              (trap_o)
    );

    // Stores and branches never write the register file
    always_comb begin
        case (op_i)
            SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU: write_enable = 1'b0;
            default:                                   write_enable = !killed_o;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Output register, frozen by stall
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            write_enable_o <= 1'b0;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_o <= alu_result;
            op_o     <= op_i;
        end
    end

endmodule

//--- test/execute_stage_chk.sv
//////////////////////////////////////////////////////////////////////
// Assertions on kill gating, trap strobes and stall, bound to the top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module execute_stage_chk (
    input logic            clk,
    input logic            reset,
    input logic            stall_i,
    input logic            killed_i,
    input logic            jump_i,
    input exec_pkg::trap_t trap_i,
    input exec_pkg::word_t result_i
);

    // Failure counts, summed by the testbench at the end of the run
    int jump_fails  = 0;
    int trap_fails  = 0;
    int stall_fails = 0;

    jump_not_killed: assert property (
        @(posedge clk) disable iff (reset) !(jump_i && killed_i)
    ) else begin
        $error("jump_o high for a killed instruction");
        jump_fails++;
    end

    // Only one trap action per instruction
    single_trap_strobe: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({trap_i.raise_exception, trap_i.machine_return, trap_i.interrupt_ack})
    ) else begin
        $error("more than one trap strobe high");
        trap_fails++;
    end

    result_held_in_stall: assert property (
        @(posedge clk) disable iff (reset) stall_i |=> $stable(result_i)
    ) else begin
        $error("result_o changed while stall_i was high");
        stall_fails++;
    end

endmodule

//--- test/execute_stage_tb.sv
//////////////////////////////////////////////////////////////////////
// Seeded random testbench for the execute stage with a reference model
// Six phases of random instructions, one line per phase and a summary
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module execute_stage_tb;

    import exec_pkg::*;

    localparam int ITEMS = 200;
    // Six phases of one item per cycle, plus reset and slack
    localparam int CYCLE_LIMIT = 6 * ITEMS + 200;

    logic      clk = 1'b0;
    logic      reset;
    logic      stall;
    op_e       op;
    word_t     pc;
    operands_t operands;
    tag_t      tag;
    logic      illegal_inst;
    logic      misaligned_fetch;
    logic      interrupt_pending;
    logic      killed;
    logic      write_enable;
    op_e       op_out;
    word_t     result;
    mem_req_t  mem_req;
    logic      jump;
    word_t     jump_target;
    trap_t     trap;

    // Reference model state
    tag_t  model_tag;
    logic  exp_we;
    word_t exp_result;
    op_e   exp_op;
    int    stall_left;
    int    pass_count;
    int    error_count;
    int    cycle_count;

    op_e alu_ops  [11] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, LUI};
    op_e flow_ops [8]  = '{JAL, JALR, BEQ, BNE, BLT, BLTU, BGE, BGEU};
    op_e mem_ops  [8]  = '{LB, LBU, LH, LHU, LW, SB, SH, SW};
    op_e sys_ops  [4]  = '{ECALL, EBREAK, MRET, NOP};

    always #2 clk = !clk;

    execute_stage i_execute_stage (
        .clk                 (clk),
        .reset               (reset),
        .stall_i             (stall),
        .op_i                (op),
        .pc_i                (pc),
        .operands_i          (operands),
        .tag_i               (tag),
        .illegal_inst_i      (illegal_inst),
        .misaligned_fetch_i  (misaligned_fetch),
        .interrupt_pending_i (interrupt_pending),
        .killed_o            (killed),
        .write_enable_o      (write_enable),
        .op_o                (op_out),
        .result_o            (result),
        .mem_req_o           (mem_req),
        .jump_o              (jump),
        .jump_target_o       (jump_target),
        .trap_o              (trap)
    );

    bind execute_stage execute_stage_chk i_execute_stage_chk (
        .clk      (clk),
        .reset    (reset),
        .stall_i  (stall_i),
        .killed_i (killed_o),
        .jump_i   (jump_o),
        .trap_i   (trap_o),
        .result_i (result_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic is_branch(input op_e o);
        return o inside {BEQ, BNE, BLT, BLTU, BGE, BGEU};
    endfunction

    function automatic logic is_load(input op_e o);
        return o inside {LB, LBU, LH, LHU, LW};
    endfunction

    function automatic logic is_store(input op_e o);
        return o inside {SB, SH, SW};
    endfunction

    function automatic word_t expected_result(input op_e o, input word_t p,
                                              input word_t a, input word_t b);
        logic signed [31:0] a_signed;
        logic [4:0]         sh;
        a_signed = a;
        sh       = b[4:0];
        case (o)
            SUB:       return a - b;
            AND:       return a & b;
            OR:        return a | b;
            XOR:       return a ^ b;
            SLL:       return a << sh;
            SRL:       return a >> sh;
            SRA:       return word_t'(a_signed >>> sh);
            SLT:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:      return (a < b) ? 32'd1 : 32'd0;
            LUI:       return b;
            JAL, JALR: return p + 32'd4;
            default:   return a + b;
        endcase
    endfunction

    function automatic logic expected_taken(input op_e o, input word_t a, input word_t b);
        case (o)
            BEQ:       return a == b;
            BNE:       return a != b;
            BLT:       return $signed(a) < $signed(b);
            BLTU:      return a < b;
            BGE:       return $signed(a) >= $signed(b);
            BGEU:      return a >= b;
            JAL, JALR: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic word_t expected_target(input op_e o, input word_t p, input word_t a,
                                              input word_t b, input word_t c);
        case (o)
            JAL:     return a + b;
            JALR:    return (a + b) & 32'hFFFF_FFFE;
            default: return p + c;
        endcase
    endfunction

    function automatic byte_en_t expected_byte_en(input op_e o, input logic [1:0] low);
        case (o)
            SB:      return 4'b0001 << low;
            SH:      return low[1] ? 4'b1100 : 4'b0011;
            SW:      return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic word_t expected_store_data(input op_e o, input word_t c);
        case (o)
            SB:      return {4{c[7:0]}};
            SH:      return {2{c[15:0]}};
            default: return c;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks and stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at time %0t: %s is %h, expected %h",
                     $time, what, actual, expected);
        end else begin
            pass_count++;
        end
    endtask

    function automatic int random_index(input int count);
        return int'($urandom_range(count - 1, 0));
    endfunction

    // Mostly the current tag, otherwise a stale one
    function automatic tag_t random_tag();
        if ($urandom_range(99, 0) < 80) begin
            return model_tag;
        end
        return model_tag + tag_t'($urandom_range(7, 1));
    endfunction

    task automatic drive_item(input int phase);
        int group;
        group           = random_index(4);
        pc              = $urandom & 32'hFFFF_FFFC;
        operands.first  = $urandom;
        operands.second = ($urandom_range(99, 0) < 20) ? operands.first : $urandom;
        operands.third  = $urandom;
        tag             = random_tag();
        stall           = 1'b0;
        illegal_inst      = 1'b0;
        misaligned_fetch  = 1'b0;
        interrupt_pending = 1'b0;
        if (phase >= 4) begin
            illegal_inst      = $urandom_range(99, 0) < 25;
            misaligned_fetch  = $urandom_range(99, 0) < 25;
            interrupt_pending = $urandom_range(99, 0) < 50;
        end
        case (phase)
            1: begin
                op  = alu_ops[random_index(11)];
                tag = model_tag;
            end
            2: op = flow_ops[random_index(8)];
            3: op = mem_ops[random_index(8)];
            4: op = sys_ops[random_index(4)];
            default: begin
                case (group)
                    0:       op = alu_ops[random_index(11)];
                    1:       op = flow_ops[random_index(8)];
                    2:       op = mem_ops[random_index(8)];
                    default: op = sys_ops[random_index(4)];
                endcase
            end
        endcase
        if (phase == 5) begin
            tag = model_tag + tag_t'($urandom_range(7, 1));
        end
        // Stall in stretches of one to five cycles
        if (phase == 6) begin
            if (stall_left == 0 && $urandom_range(99, 0) < 30) begin
                stall_left = int'($urandom_range(5, 1));
            end
            stall = stall_left != 0;
            if (stall_left != 0) begin
                stall_left--;
            end
        end
    endtask

    // Same-cycle outputs, then the values due at the next edge
    task automatic evaluate_cycle();
        word_t      sum;
        logic       killed_exp;
        logic       jump_exp;
        logic       raise_exp;
        logic       mret_exp;
        logic       ack_exp;
        logic [3:0] cause_exp;
        sum        = operands.first + operands.second;
        killed_exp = tag != model_tag;
        jump_exp   = expected_taken(op, operands.first, operands.second) && !killed_exp;
        check_value(word_t'(killed), word_t'(killed_exp), "killed_o");
        check_value(word_t'(jump), word_t'(jump_exp), "jump_o");
        if (is_branch(op) || op == JAL || op == JALR) begin
            check_value(jump_target, expected_target(op, pc, operands.first,
                        operands.second, operands.third), "jump_target_o");
        end
        check_value(mem_req.address, sum & 32'hFFFF_FFFC, "mem address");
        check_value(word_t'(mem_req.read_enable), word_t'(is_load(op)), "mem read enable");
        check_value(word_t'(mem_req.write_enable),
                    word_t'(expected_byte_en(op, sum[1:0])), "mem byte enable");
        if (is_store(op)) begin
            check_value(mem_req.write_data, expected_store_data(op, operands.third),
                        "mem write data");
        end

        // Trap priority, first match wins
        raise_exp = 1'b0;
        mret_exp  = 1'b0;
        ack_exp   = 1'b0;
        cause_exp = 4'd15;
        if (!killed_exp) begin
            if (illegal_inst) begin
                raise_exp = 1'b1;
                cause_exp = 4'd2;
            end else if (misaligned_fetch) begin
                raise_exp = 1'b1;
                cause_exp = 4'd0;
            end else if (op == ECALL) begin
                raise_exp = 1'b1;
                cause_exp = 4'd11;
            end else if (op == EBREAK) begin
                raise_exp = 1'b1;
                cause_exp = 4'd3;
            end else if (op == MRET) begin
                mret_exp = 1'b1;
            end else if (interrupt_pending) begin
                ack_exp = 1'b1;
            end
        end
        check_value(word_t'(trap.raise_exception), word_t'(raise_exp), "raise_exception");
        check_value(word_t'(trap.machine_return), word_t'(mret_exp), "machine_return");
        check_value(word_t'(trap.interrupt_ack), word_t'(ack_exp), "interrupt_ack");
        check_value(word_t'(trap.exception_code), word_t'(cause_exp), "exception_code");

        if (!stall) begin
            exp_we     = !killed_exp && !is_store(op) && !is_branch(op);
            exp_result = expected_result(op, pc, operands.first, operands.second);
            exp_op     = op;
        end
        if (jump_exp || raise_exp || mret_exp || ack_exp) begin
            model_tag = model_tag + 3'd1;
        end
    endtask

    task automatic check_registered();
        check_value(word_t'(write_enable), word_t'(exp_we), "write_enable_o");
        check_value(result, exp_result, "result_o");
        check_value(word_t'(op_out), word_t'(exp_op), "op_o");
    endtask

    // A jump with a pending interrupt must stay quiet during reset
    task automatic apply_reset();
        @(posedge clk);
        #1;
        check_value(word_t'(jump), 32'd0, "jump_o in reset");
        check_value(word_t'(trap.raise_exception), 32'd0, "raise_exception in reset");
        check_value(word_t'(trap.machine_return), 32'd0, "machine_return in reset");
        check_value(word_t'(trap.interrupt_ack), 32'd0, "interrupt_ack in reset");
        @(posedge clk);
        #1;
        check_value(word_t'(write_enable), 32'd0, "write_enable_o after reset");
        reset             = 1'b0;
        op                = NOP;
        interrupt_pending = 1'b0;
        #2;
        evaluate_cycle();
    endtask

    task automatic run_phase(input int phase, input string name);
        int errors_before;
        int item;
        errors_before = error_count;
        for (item = 0; item < ITEMS; item++) begin
            @(posedge clk);
            #1;
            check_registered();
            drive_item(phase);
            #2;
            evaluate_cycle();
        end
        $display("Phase %0d %s: %0d items, %0d errors",
                 phase, name, ITEMS, error_count - errors_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : main_sequence
        int assert_errors;
        void'($urandom(61));
        reset             = 1'b1;
        stall             = 1'b0;
        op                = JAL;
        pc                = '0;
        operands          = '0;
        tag               = '0;
        illegal_inst      = 1'b0;
        misaligned_fetch  = 1'b0;
        interrupt_pending = 1'b1;
        model_tag         = '0;
        exp_we            = 1'b0;
        exp_result        = '0;
        exp_op            = NOP;
        stall_left        = 0;
        pass_count        = 0;
        error_count       = 0;
        apply_reset();
        run_phase(1, "ALU results");
        run_phase(2, "branches and jumps");
        run_phase(3, "loads and stores");
        run_phase(4, "trap priority");
        run_phase(5, "killed instructions");
        run_phase(6, "stall");
        assert_errors = i_execute_stage.i_execute_stage_chk.jump_fails
                      + i_execute_stage.i_execute_stage_chk.trap_fails
                      + i_execute_stage.i_execute_stage_chk.stall_fails;
        $display("Summary: %0d checks passed, %0d errors, %0d assertion failures",
                 pass_count, error_count, assert_errors);
        if (error_count == 0 && assert_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- execute_stage.f
+incdir+include
logic/exec_pkg.sv
logic/alu_branch.sv
logic/load_store_unit.sv
logic/flow_control.sv
logic/execute_stage.sv
test/execute_stage_chk.sv
test/execute_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 \
    --top-module execute_stage_tb -f execute_stage.f

status=0
./obj_dir/Vexecute_stage_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
    echo "Run reported failures, see sim.log"
    exit 1
fi
echo "Run finished without failures"
